//--- mems_scan.f
verilog/mems_scan_pkg.sv
verilog/dac_cmd_pkg.sv
verilog/cmd_link_if.sv
verilog/dac_spi_lane.sv
verilog/scan_event_merge.sv
verilog/mems_control.sv
verilog/mems_scan_top.sv
tests/tb_clock_gen.sv
tests/mems_scan_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the MEMS scan testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f mems_scan.f --top-module mems_scan_tb -o mems_scan_sim \
  && ./obj_dir/mems_scan_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/mems_scan_tb.sv
`timescale 1ns/10ps

module mems_scan_tb import mems_scan_pkg::*, dac_cmd_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int TB_SCAN_END     = 1300;
  localparam int TB_FIRST_LINE   = 540;
  localparam int TB_LINE_PITCH   = 64;
  localparam int TB_LINES_FRAME  = 3;
  localparam int SCAN_LEN        = TB_SCAN_END - SCAN_START + 1;
  localparam int WRAP_EXTRA      = 20;   // words past the wrap
  localparam int RESUME_WORDS    = 10;
  localparam int WORD_CYC        = 2 * SCLK_DIV * DAC_WORD_BITS + 4;
  localparam int TOTAL_WORDS     = 2 + SCAN_LEN + WRAP_EXTRA + RESUME_WORDS + LANE_DEPTH + 8;
  localparam int WATCHDOG_NS     = (3 * TOTAL_WORDS * WORD_CYC / 2) * CLK_PERIOD;
  localparam logic [31:0] SEED   = 32'd59907;

  logic                       clk;
  logic                       mems_soft_reset;
  logic                       start;
  logic                       pause;
  logic [NUM_LANES-1:0][15:0] rom_data;
  logic                       new_line_fifo_done;
  logic                       new_frame_fifo_done;
  logic [15:0]                addr;
  logic                       new_line;
  logic                       new_frame;
  logic [NUM_LANES-1:0]       dac_sclk;
  logic [NUM_LANES-1:0]       dac_cs_n;
  logic [NUM_LANES-1:0]       dac_mosi;

  logic [23:0]          rx_q [NUM_LANES][$];  // words rebuilt from the SPI pins
  int                   rx_cnt [NUM_LANES];
  int                   checked [NUM_LANES];
  logic [23:0]          shreg [NUM_LANES];
  int                   bit_cnt [NUM_LANES];
  int                   low_cnt [NUM_LANES];
  int                   high_cnt [NUM_LANES];
  logic [NUM_LANES-1:0] cs_prev;
  logic [NUM_LANES-1:0] sclk_prev;
  logic [1:0]           mk_prev;   // line in bit 0 and frame in bit 1
  logic [1:0]           ack_prev;
  logic [1:0]           due;
  int                   hold [2];
  int                   rise_cnt [2];
  int                   full_seen;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) i_clock_gen (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset)
  );

  mems_scan_top #(
    .SCAN_END        (TB_SCAN_END),
    .FIRST_LINE_ADDR (TB_FIRST_LINE),
    .LINE_PITCH      (TB_LINE_PITCH),
    .LINES_PER_FRAME (TB_LINES_FRAME)
  ) i_mems_scan_top (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .start               (start),
    .pause               (pause),
    .rom_data            (rom_data),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .addr                (addr),
    .new_line            (new_line),
    .new_frame           (new_frame),
    .dac_sclk            (dac_sclk),
    .dac_cs_n            (dac_cs_n),
    .dac_mosi            (dac_mosi)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // every address bit and the lane feed the table hash
  function automatic logic [15:0] table_code(input int a, input int lane);
    logic [31:0] h;
    h = xorshift32(SEED ^ (32'(a) << 4) ^ 32'(lane));
    h = xorshift32(h);
    return h[15:0];
  endfunction

  function automatic int scan_addr(input int k);
    return SCAN_START + k % SCAN_LEN;
  endfunction

  function automatic bit is_line(input int a);
    return a >= TB_FIRST_LINE && (a - TB_FIRST_LINE) % TB_LINE_PITCH == 0;
  endfunction

  function automatic bit is_frame(input int a);
    return is_line(a) && ((a - TB_FIRST_LINE) / TB_LINE_PITCH) % TB_LINES_FRAME == 0;
  endfunction

  // word n of a lane counts two setup words before the scan
  function automatic logic [23:0] expected_word(input int lane, input int n);
    int a;
    if (n == 0) return DAC_RESET_WORD;
    if (n == 1) return DAC_VREF_WORD;
    a = scan_addr(n - 2);
    return {CMD_WRITE_UPDATE, 4'(lane), table_code(a, lane)};
  endfunction

  function automatic int count_marks(input int n_scan, input bit frame);
    int c;
    c = 0;
    for (int k = 0; k < n_scan; k++) begin
      if (frame ? is_frame(scan_addr(k)) : is_line(scan_addr(k))) c++;
    end
    return c;
  endfunction

  function automatic int min_rx();
    int m;
    m = rx_cnt[0];
    for (int l = 1; l < NUM_LANES; l++) begin
      if (rx_cnt[l] < m) m = rx_cnt[l];
    end
    return m;
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Error: %0t ns %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // table answers a little after each edge
  initial begin
    rom_data = '0;
    forever begin
      @(posedge clk);
      #2;
      for (int l = 0; l < NUM_LANES; l++) rom_data[l] = table_code(int'(addr), l);
    end
  end

  // consumer acks each marker after it has been high for three cycles
  initial begin
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      new_line_fifo_done  = (hold[0] == 3);
      new_frame_fifo_done = (hold[1] == 3);
    end
  end

  // DAC models and marker checks sample mid cycle
  always @(negedge clk) begin : monitor
    logic [1:0] mk_now;
    int         full_now;
    if (mems_soft_reset) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        rx_q[l].delete();
        rx_cnt[l]   = 0;
        bit_cnt[l]  = 0;
        low_cnt[l]  = 0;
        high_cnt[l] = 2;
      end
      cs_prev   = '1;
      sclk_prev = '0;
      mk_prev   = '0;
      ack_prev  = '0;
      due       = '0;
      hold      = '{0, 0};
      rise_cnt  = '{0, 0};
      full_seen = 0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (!dac_cs_n[l]) begin
          if (cs_prev[l]) begin
            expect_equal(32'(high_cnt[l] >= 2), 32'd1, $sformatf("lane %0d cs_n gap", l));
            bit_cnt[l] = 0;
            low_cnt[l] = 0;
          end
          low_cnt[l]++;
          high_cnt[l] = 0;
          if (sclk_prev[l] && !dac_sclk[l]) begin  // DAC samples on falling sclk
            shreg[l] = {shreg[l][22:0], dac_mosi[l]};
            bit_cnt[l]++;
          end
        end else begin
          if (!cs_prev[l]) begin
            expect_equal(32'(bit_cnt[l]), 32'(DAC_WORD_BITS), $sformatf("lane %0d bits", l));
            expect_equal(32'(low_cnt[l]), 32'(2 * SCLK_DIV * DAC_WORD_BITS),
                         $sformatf("lane %0d cs_n low cycles", l));
            rx_q[l].push_back(shreg[l]);
            rx_cnt[l]++;
          end
          high_cnt[l]++;
        end
      end
      cs_prev   = dac_cs_n;
      sclk_prev = dac_sclk;

      mk_now = {new_frame, new_line};
      for (int m = 0; m < 2; m++) begin
        if (due[m]) begin
          expect_equal(32'(mk_now[m]), 32'd1,
                       $sformatf("%s marker missing", m ? "frame" : "line"));
        end else if (mk_now[m] && !mk_prev[m]) begin
          expect_equal(32'(mk_now[m]), 32'd0,
                       $sformatf("%s marker at unmarked word", m ? "frame" : "line"));
        end
        if (mk_prev[m] && !mk_now[m]) begin
          expect_equal(32'(ack_prev[m]), 32'd1,
                       $sformatf("%s marker dropped without ack", m ? "frame" : "line"));
        end
        if (mk_now[m] && !mk_prev[m]) rise_cnt[m]++;
        hold[m] = mk_now[m] ? hold[m] + 1 : 0;
        due[m]  = 1'b0;
      end
      mk_prev  = mk_now;
      ack_prev = {new_frame_fifo_done, new_line_fifo_done};

      // a word counts once the last lane has finished it
      full_now = min_rx();
      for (int n = full_seen; n < full_now; n++) begin
        if (n >= 2) begin
          due[0] = due[0] | is_line(scan_addr(n - 2));
          due[1] = due[1] | is_frame(scan_addr(n - 2));
        end
      end
      full_seen = full_now;
    end
  end

  task automatic check_words(input int upto);
    logic [23:0] got;
    while (min_rx() < upto) @(negedge clk);
    for (int l = 0; l < NUM_LANES; l++) begin
      while (checked[l] < upto) begin
        got = rx_q[l].pop_front();
        expect_equal(32'(got), 32'(expected_word(l, checked[l])),
                     $sformatf("lane %0d word %0d", l, checked[l]));
        checked[l]++;
      end
    end
  endtask

  task automatic idle_after_reset();
    repeat (10) begin
      @(negedge clk);
      expect_equal(32'(dac_cs_n), 32'({NUM_LANES{1'b1}}), "cs_n before start");
      expect_equal(32'(dac_sclk), 32'd0, "sclk before start");
      expect_equal(32'({new_frame, new_line}), 32'd0, "markers before start");
      expect_equal(32'(addr), 32'd0, "addr before start");
      expect_equal(32'(min_rx()), 32'd0, "words before start");
    end
  endtask

  task automatic start_and_setup();
    @(posedge clk);
    #2 start = 1'b1;
    @(posedge clk);
    #2 start = 1'b0;
    check_words(2);
  endtask

  task automatic full_scan_with_wrap();
    int n_scan;
    n_scan = SCAN_LEN + WRAP_EXTRA;
    check_words(2 + n_scan);
    repeat (2) @(negedge clk);
    expect_equal(32'(rise_cnt[0]), 32'(count_marks(n_scan, 1'b0)), "line marker count");
    expect_equal(32'(rise_cnt[1]), 32'(count_marks(n_scan, 1'b1)), "frame marker count");
  endtask

  task automatic pause_and_resume();
    int base [NUM_LANES];
    int upto;
    @(posedge clk);
    #2 pause = 1'b1;
    for (int l = 0; l < NUM_LANES; l++) base[l] = rx_cnt[l];
    repeat ((LANE_DEPTH + 2) * WORD_CYC) @(negedge clk);  // queued words drain
    for (int l = 0; l < NUM_LANES; l++) begin
      expect_equal(32'(rx_cnt[l] - base[l] <= LANE_DEPTH + 1), 32'd1,
                   $sformatf("lane %0d words after pause", l));
    end
    repeat (2 * WORD_CYC) begin
      @(negedge clk);
      expect_equal(32'(dac_cs_n), 32'({NUM_LANES{1'b1}}), "transfer while paused");
    end
    upto = min_rx() + RESUME_WORDS;
    @(posedge clk);
    #2 pause = 1'b0;
    check_words(upto);  // sequence index runs on without skip or repeat
  endtask

  initial begin
    start = 1'b0;
    pause = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) checked[l] = 0;
    @(negedge mems_soft_reset);
    idle_after_reset();
    start_and_setup();
    full_scan_with_wrap();
    pause_and_resume();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DACs did not receive the expected words in time");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic mems_soft_reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset seen high by the first RESET_CYCLES rising edges
  initial begin
    mems_soft_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 mems_soft_reset = 1'b0;
  end

endmodule

//--- verilog/mems_scan_top.sv
`timescale 1ns/10ps

module mems_scan_top import mems_scan_pkg::*; #(
  parameter int NUM_LANES       = mems_scan_pkg::NUM_LANES,
  parameter int SCAN_START      = mems_scan_pkg::SCAN_START,
  parameter int SCAN_END        = mems_scan_pkg::SCAN_END,
  parameter int FIRST_LINE_ADDR = mems_scan_pkg::FIRST_LINE_ADDR,
  parameter int LINE_PITCH      = mems_scan_pkg::LINE_PITCH,
  parameter int LINES_PER_FRAME = mems_scan_pkg::LINES_PER_FRAME,
  parameter int LANE_DEPTH      = mems_scan_pkg::LANE_DEPTH,
  parameter int SCLK_DIV        = dac_cmd_pkg::SCLK_DIV
) (
  input  logic                       clk,
  input  logic                       mems_soft_reset,
  input  logic                       start,
  input  logic                       pause,
  input  logic [NUM_LANES-1:0][15:0] rom_data,   // lane i on slice i
  input  logic                       new_line_fifo_done,
  input  logic                       new_frame_fifo_done,
  output logic [15:0]                addr,
  output logic                       new_line,
  output logic                       new_frame,
  output logic [NUM_LANES-1:0]       dac_sclk,
  output logic [NUM_LANES-1:0]       dac_cs_n,
  output logic [NUM_LANES-1:0]       dac_mosi
);

  logic [NUM_LANES-1:0]      done_valid;
  scan_tag_t [NUM_LANES-1:0] done_tag;

  cmd_link_if link [NUM_LANES] ();  // one link per lane

  mems_control #(
    .NUM_LANES       (NUM_LANES),
    .SCAN_START      (SCAN_START),
    .SCAN_END        (SCAN_END),
    .FIRST_LINE_ADDR (FIRST_LINE_ADDR),
    .LINE_PITCH      (LINE_PITCH),
    .LINES_PER_FRAME (LINES_PER_FRAME),
    .LANE_DEPTH      (LANE_DEPTH)
  ) i_mems_control (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (start),
    .pause           (pause),
    .rom_data        (rom_data),
    .addr            (addr),
    .link            (link)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    dac_spi_lane #(
      .LANE_DEPTH (LANE_DEPTH),
      .SCLK_DIV   (SCLK_DIV)
    ) i_dac_spi_lane (
      .clk             (clk),
      .mems_soft_reset (mems_soft_reset),
      .link            (link[g]),
      .sclk            (dac_sclk[g]),
      .cs_n            (dac_cs_n[g]),
      .mosi            (dac_mosi[g]),
      .done_valid      (done_valid[g]),
      .done_tag        (done_tag[g])
    );
  end

  scan_event_merge #(
    .NUM_LANES (NUM_LANES)
  ) i_scan_event_merge (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .done_valid          (done_valid),
    .done_tag            (done_tag),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .new_line            (new_line),
    .new_frame           (new_frame)
  );

endmodule

//--- verilog/mems_control.sv
`timescale 1ns/10ps

module mems_control import mems_scan_pkg::*, dac_cmd_pkg::*; #(
  parameter int NUM_LANES       = mems_scan_pkg::NUM_LANES,
  parameter int SCAN_START      = mems_scan_pkg::SCAN_START,
  parameter int SCAN_END        = mems_scan_pkg::SCAN_END,
  parameter int FIRST_LINE_ADDR = mems_scan_pkg::FIRST_LINE_ADDR,
  parameter int LINE_PITCH      = mems_scan_pkg::LINE_PITCH,
  parameter int LINES_PER_FRAME = mems_scan_pkg::LINES_PER_FRAME,
  parameter int LANE_DEPTH      = mems_scan_pkg::LANE_DEPTH
) (
  input  logic                       clk,
  input  logic                       mems_soft_reset,
  input  logic                       start,
  input  logic                       pause,
  input  logic [NUM_LANES-1:0][15:0] rom_data,
  output logic [15:0]                addr,
  cmd_link_if.sender                 link [NUM_LANES]
);

  localparam int CW = $clog2(LANE_DEPTH + 1);
  localparam int LW = (LINES_PER_FRAME > 1) ? $clog2(LINES_PER_FRAME) : 1;

  typedef enum logic [2:0] {
    IDLE,
    SOFT_RESET,
    VREF_SETUP,
    SCAN_FETCH,
    SCAN_SEND
  } state_t;

  state_t               state_q;
  logic [NUM_LANES-1:0] has_credit;
  logic                 step_ok;
  logic                 send;
  logic                 valid_q;
  logic                 is_line;
  logic [16:0]          next_line_q;  // one bit wider so it never aliases back
  logic [LW-1:0]        line_idx_q;
  scan_tag_t            tag_q;

  // one step every two cycles at most, all lanes together
  assign step_ok = (&has_credit) & ~valid_q & ~pause;
  assign is_line = ({1'b0, addr} == next_line_q);

  always_comb begin
    case (state_q)
      SOFT_RESET: send = step_ok;
      VREF_SETUP: send = step_ok;
      SCAN_SEND:  send = step_ok;
      default:    send = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q     <= IDLE;
      addr        <= '0;
      valid_q     <= 1'b0;
      next_line_q <= 17'(FIRST_LINE_ADDR);
      line_idx_q  <= '0;
    end else begin
      valid_q <= send;
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= SOFT_RESET;
          end
        end
        SOFT_RESET: begin
          if (send) begin
            state_q <= VREF_SETUP;
          end
        end
        VREF_SETUP: begin
          if (send) begin
            state_q     <= SCAN_FETCH;
            addr        <= 16'(SCAN_START);
            next_line_q <= 17'(FIRST_LINE_ADDR);
            line_idx_q  <= '0;
          end
        end
        SCAN_FETCH: begin
          state_q <= SCAN_SEND;  // table answers within this cycle
        end
        SCAN_SEND: begin
          if (send) begin
            state_q <= SCAN_FETCH;
            if (is_line) begin
              next_line_q <= next_line_q + 17'(LINE_PITCH);
              line_idx_q  <= (line_idx_q == LW'(LINES_PER_FRAME - 1)) ? '0 :
                             line_idx_q + 1'b1;
            end
            if (addr == 16'(SCAN_END)) begin
              addr        <= 16'(SCAN_START);  // wrap, line tracking restarts
              next_line_q <= 17'(FIRST_LINE_ADDR);
              line_idx_q  <= '0;
            end else begin
              addr <= addr + 16'd1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // tag shared by all lanes of a step
  always_ff @(posedge clk) begin
    if (send) begin
      tag_q.line  <= (state_q == SCAN_SEND) & is_line;
      tag_q.frame <= (state_q == SCAN_SEND) & is_line & (line_idx_q == '0);
    end
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    logic [CW-1:0] credit_cnt;
    dac_word_t     word_q;

    always_ff @(posedge clk) begin
      if (mems_soft_reset) begin
        credit_cnt <= CW'(LANE_DEPTH);
      end else begin
        credit_cnt <= credit_cnt - CW'(valid_q) + CW'(link[g].credit);
      end
    end

    always_ff @(posedge clk) begin
      if (send) begin
        case (state_q)
          SOFT_RESET: word_q <= DAC_RESET_WORD;
          VREF_SETUP: word_q <= DAC_VREF_WORD;
          default:    word_q <= '{cmd: CMD_WRITE_UPDATE, chan: 4'(g), data: rom_data[g]};
        endcase
      end
    end

    assign has_credit[g] = (credit_cnt != '0);
    assign link[g].valid = valid_q;
    assign link[g].word  = word_q;
    assign link[g].tag   = tag_q;

    // lane never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (mems_soft_reset)
      credit_cnt <= CW'(LANE_DEPTH));

    a_send_with_credit: assert property (@(posedge clk) disable iff (mems_soft_reset)
      valid_q |-> credit_cnt != '0);
  end

endmodule

//--- verilog/scan_event_merge.sv
`timescale 1ns/10ps

module scan_event_merge import mems_scan_pkg::*; #(
  parameter int NUM_LANES = mems_scan_pkg::NUM_LANES
) (
  input  logic                      clk,
  input  logic                      mems_soft_reset,
  input  logic [NUM_LANES-1:0]      done_valid,
  input  scan_tag_t [NUM_LANES-1:0] done_tag,
  input  logic                      new_line_fifo_done,
  input  logic                      new_frame_fifo_done,
  output logic                      new_line,
  output logic                      new_frame
);

  localparam int CNT_W = 4;  // lanes drift apart by a few words only
  localparam int SEQ_W = 8;

  logic [NUM_LANES-1:0]            line_in;
  logic [NUM_LANES-1:0]            frame_in;
  logic [NUM_LANES-1:0]            line_seen;
  logic [NUM_LANES-1:0]            frame_seen;
  logic [NUM_LANES-1:0][CNT_W-1:0] line_cnt;
  logic [NUM_LANES-1:0][CNT_W-1:0] frame_cnt;
  logic [NUM_LANES-1:0][SEQ_W-1:0] seq;  // completions per lane
  logic                            line_join;
  logic                            frame_join;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      line_in[i]    = done_valid[i] & done_tag[i].line;
      frame_in[i]   = done_valid[i] & done_tag[i].frame;
      line_seen[i]  = line_in[i] | (line_cnt[i] != '0);
      frame_seen[i] = frame_in[i] | (frame_cnt[i] != '0);
    end
  end

  assign line_join  = &line_seen;   // last lane just caught up
  assign frame_join = &frame_seen;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      line_cnt  <= '0;
      frame_cnt <= '0;
      seq       <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        line_cnt[i]  <= line_cnt[i] + CNT_W'(line_in[i]) - CNT_W'(line_join);
        frame_cnt[i] <= frame_cnt[i] + CNT_W'(frame_in[i]) - CNT_W'(frame_join);
        seq[i]       <= seq[i] + SEQ_W'(done_valid[i]);
      end
    end
  end

  // sticky markers, a new event wins over an ack in the same cycle
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      if (line_join) begin
        new_line <= 1'b1;
      end else if (new_line_fifo_done) begin
        new_line <= 1'b0;
      end
      if (frame_join) begin
        new_frame <= 1'b1;
      end else if (new_frame_fifo_done) begin
        new_frame <= 1'b0;
      end
    end
  end

  for (genvar g = 1; g < NUM_LANES; g++) begin : g_tag_check
    a_tag_agree: assert property (@(posedge clk) disable iff (mems_soft_reset)
      (done_valid[0] && done_valid[g] && seq[0] == seq[g]) |-> done_tag[g] == done_tag[0]);
  end

endmodule

//--- verilog/dac_spi_lane.sv
`timescale 1ns/10ps

module dac_spi_lane import mems_scan_pkg::*, dac_cmd_pkg::*; #(
  parameter int LANE_DEPTH = mems_scan_pkg::LANE_DEPTH,
  parameter int SCLK_DIV   = dac_cmd_pkg::SCLK_DIV
) (
  input  logic      clk,
  input  logic      mems_soft_reset,
  cmd_link_if.lane  link,
  output logic      sclk,
  output logic      cs_n,
  output logic      mosi,
  output logic      done_valid,
  output scan_tag_t done_tag
);

  localparam int PW     = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
  localparam int QW     = $clog2(LANE_DEPTH + 1);
  localparam int DW     = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
  localparam int HALVES = 2 * DAC_WORD_BITS;
  localparam int HW     = $clog2(HALVES);

  typedef struct packed {
    dac_word_t word;
    scan_tag_t tag;
  } entry_t;

  entry_t                   queue_mem [LANE_DEPTH];
  entry_t                   head;
  logic [PW-1:0]            wr_ptr;
  logic [PW-1:0]            rd_ptr;
  logic [QW-1:0]            q_count;
  logic                     pop;
  logic                     busy;
  logic                     gap_q;
  logic                     half_end;
  logic                     word_end;
  logic                     rise_next;
  logic [DW-1:0]            div_cnt;
  logic [HW-1:0]            half_cnt;
  logic [DAC_WORD_BITS-1:0] shift_q;
  scan_tag_t                cur_tag;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(LANE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head      = queue_mem[rd_ptr];
  assign pop       = ~busy & ~gap_q & (q_count != '0);
  assign half_end  = busy & (div_cnt == DW'(SCLK_DIV - 1));
  assign word_end  = half_end & (half_cnt == HW'(HALVES - 1));
  assign rise_next = half_end & ~word_end & ~sclk;  // next edge is sclk rising

  assign link.credit = pop;  // slot frees as the word enters the shifter
  assign mosi        = shift_q[DAC_WORD_BITS-1];
  assign done_tag    = cur_tag;

  always_ff @(posedge clk) begin
    if (link.valid) begin
      queue_mem[wr_ptr] <= '{word: link.word, tag: link.tag};
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (link.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      q_count <= q_count + QW'(link.valid) - QW'(pop);
    end
  end

  // mode 1 shifter, cs_n low for HALVES * SCLK_DIV cycles
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy       <= 1'b0;
      cs_n       <= 1'b1;
      sclk       <= 1'b0;
      gap_q      <= 1'b0;
      done_valid <= 1'b0;
      div_cnt    <= '0;
      half_cnt   <= '0;
      shift_q    <= '0;
    end else begin
      gap_q      <= word_end;  // keeps cs_n high a second cycle
      done_valid <= word_end;
      if (pop) begin
        busy     <= 1'b1;
        cs_n     <= 1'b0;
        sclk     <= 1'b1;      // first rising edge, MSB goes out
        div_cnt  <= '0;
        half_cnt <= '0;
        shift_q  <= head.word;
      end else if (busy) begin
        div_cnt <= half_end ? '0 : div_cnt + 1'b1;
        if (word_end) begin
          busy <= 1'b0;
          cs_n <= 1'b1;
          sclk <= 1'b0;
        end else if (half_end) begin
          half_cnt <= half_cnt + 1'b1;
          sclk     <= ~sclk;
        end
        if (rise_next) begin
          shift_q <= {shift_q[DAC_WORD_BITS-2:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      cur_tag <= head.tag;
    end
  end

  // sender credit accounting keeps the queue from overflowing
  a_no_push_when_full: assert property (@(posedge clk) disable iff (mems_soft_reset)
    link.valid |-> q_count < QW'(LANE_DEPTH));

endmodule

//--- verilog/cmd_link_if.sv
`timescale 1ns/10ps

// one link per lane between the sequencer and a SPI lane
// the sender spends a credit for every valid cycle, the lane
// pulses credit when a queued word moves into its shifter
interface cmd_link_if import mems_scan_pkg::*, dac_cmd_pkg::*; ();

  logic      valid;   // one cycle per word
  dac_word_t word;    // DAC word to shift out
  scan_tag_t tag;     // returned with the completion
  logic      credit;  // queue slot freed

  modport sender (
    output valid,
    output word,
    output tag,
    input  credit
  );

  modport lane (
    input  valid,
    input  word,
    input  tag,
    output credit
  );

endinterface

//--- verilog/dac_cmd_pkg.sv
package dac_cmd_pkg;

  localparam int DAC_WORD_BITS = 24;

  // system clocks per sclk half period
  localparam int SCLK_DIV = 2;

  // DAC input shift register layout, MSB first on the wire
  typedef struct packed {
    logic [3:0]  cmd;   // command nibble
    logic [3:0]  chan;  // channel address
    logic [15:0] data;  // code or command argument
  } dac_word_t;

  // command codes
  localparam logic [3:0] CMD_WRITE_UPDATE = 4'b0011;  // write and update channel n
  localparam logic [3:0] CMD_SOFT_RESET   = 4'b0110;  // software reset to power-on state
  localparam logic [3:0] CMD_REF_SETUP    = 4'b0111;  // reference select

  // fixed setup words sent once after start
  localparam dac_word_t DAC_RESET_WORD = '{
    cmd:  CMD_SOFT_RESET,
    chan: 4'h0,
    data: 16'h0000
  };

  localparam dac_word_t DAC_VREF_WORD = '{
    cmd:  CMD_REF_SETUP,
    chan: 4'h0,
    data: 16'h0001   // bit 0 set, internal ref off, external ref in use
  };

endpackage

//--- verilog/mems_scan_pkg.sv
package mems_scan_pkg;

  // number of DACs, one per mirror axis
  localparam int NUM_LANES = 2;

  // scan table walk, wraps from end back to start
  localparam int SCAN_START = 8;
  localparam int SCAN_END   = 11524;

  // line start rule
  localparam int FIRST_LINE_ADDR = 540;   // first line start address
  localparam int LINE_PITCH      = 640;   // addresses between line starts
  localparam int LINES_PER_FRAME = 9;     // every n-th line start opens a frame

  // per-lane queue depth, also the credits per lane
  localparam int LANE_DEPTH = 2;

  // marker tag carried with each word and returned on completion
  typedef struct packed {
    logic line;   // word belongs to a line start address
    logic frame;  // word belongs to a frame start address
  } scan_tag_t;

  localparam scan_tag_t TAG_NONE = '{line: 1'b0, frame: 1'b0};

endpackage
